// File: issue_stage.f
hdl/sched_pkg.sv
hdl/rob_table.sv
hdl/ready_scan.sv
hdl/sync_scan.sv
hdl/issue_select.sv
hdl/issue_stage.sv
test/issue_stage_tb.sv

// File: Makefile
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := issue_stage_tb
FILELIST  := issue_stage.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the simulator output
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: test/issue_stage_tb.sv
// Directed testbench for the issue stage, with a reference model of the ROB
// Compile with the file list in the project root, the top module is issue_stage_tb

`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb;

	import sched_pkg::*;

	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int RESET_CYCLES    = 10;
	// Longest wait for grants or retire before a test gives up
	localparam int WAIT_LIMIT      = 60;

	logic       clk;
	logic       rst;
	logic       disp_v_i;
	unit_t      disp_unit_i;
	logic       disp_alu0_only_i;
	logic       disp_sync_i;
	logic [2:0] disp_args_v_i;
	logic       wake_v_i;
	rob_ndx_t   wake_ndx_i;
	logic       done_v_i;
	rob_ndx_t   done_ndx_i;
	logic       alu0_idle_i;
	logic       alu1_idle_i;
	logic       fpu_idle_i;
	logic       fcu_idle_i;
	logic       agen_idle_i;
	rob_ndx_t   alu0_rndx_o;
	logic       alu0_rndxv_o;
	rob_ndx_t   alu1_rndx_o;
	logic       alu1_rndxv_o;
	rob_ndx_t   fpu_rndx_o;
	logic       fpu_rndxv_o;
	rob_ndx_t   fcu_rndx_o;
	logic       fcu_rndxv_o;
	rob_ndx_t   agen_rndx_o;
	logic       agen_rndxv_o;
	logic       commit_v_o;
	rob_ndx_t   commit_ndx_o;
	logic       rob_full_o;

	// ========================================================================
	// Reference model and logs
	// ========================================================================

	logic       m_v [ROB_ENTRIES];
	unit_t      m_unit [ROB_ENTRIES];
	logic       m_alu0_only [ROB_ENTRIES];
	logic       m_sync [ROB_ENTRIES];
	logic [2:0] m_args [ROB_ENTRIES];
	logic       m_done [ROB_ENTRIES];
	logic       m_granted [ROB_ENTRIES];
	rob_ndx_t   m_head;
	rob_ndx_t   m_tail;
	int         m_count;

	// Grants in the order seen, port 0 to 4 is alu0, alu1, fpu, fcu, agen
	rob_ndx_t   g_ndx [$];
	int         g_port [$];
	int         g_cyc [$];
	rob_ndx_t   c_ndx [$];
	// Idle levels that the DUT sampled at the last rising edge
	logic       idle_at_edge [5];
	int         cycle_cnt;
	int         err_cnt;
	int         check_cnt;
	int         tests_run;
	logic [31:0] lfsr_state;

	issue_stage issue_stage_i (
		.clk              (clk),
		.rst              (rst),
		.disp_v_i         (disp_v_i),
		.disp_unit_i      (disp_unit_i),
		.disp_alu0_only_i (disp_alu0_only_i),
		.disp_sync_i      (disp_sync_i),
		.disp_args_v_i    (disp_args_v_i),
		.wake_v_i         (wake_v_i),
		.wake_ndx_i       (wake_ndx_i),
		.done_v_i         (done_v_i),
		.done_ndx_i       (done_ndx_i),
		.alu0_idle_i      (alu0_idle_i),
		.alu1_idle_i      (alu1_idle_i),
		.fpu_idle_i       (fpu_idle_i),
		.fcu_idle_i       (fcu_idle_i),
		.agen_idle_i      (agen_idle_i),
		.alu0_rndx_o      (alu0_rndx_o),
		.alu0_rndxv_o     (alu0_rndxv_o),
		.alu1_rndx_o      (alu1_rndx_o),
		.alu1_rndxv_o     (alu1_rndxv_o),
		.fpu_rndx_o       (fpu_rndx_o),
		.fpu_rndxv_o      (fpu_rndxv_o),
		.fcu_rndx_o       (fcu_rndx_o),
		.fcu_rndxv_o      (fcu_rndxv_o),
		.agen_rndx_o      (agen_rndx_o),
		.agen_rndxv_o     (agen_rndxv_o),
		.commit_v_o       (commit_v_o),
		.commit_ndx_o     (commit_ndx_o),
		.rob_full_o       (rob_full_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ========================================================================
	// Compare tasks and random bits
	// ========================================================================

	task automatic check_ndx(input string what, input rob_ndx_t got, input rob_ndx_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	// Galois LFSR, one step per bit handed out
	function automatic bit rand_bit();
		bit b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return b;
	endfunction

	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r[k] = rand_bit();
		end
		return r;
	endfunction

	// ========================================================================
	// Clock stepping with model update
	// ========================================================================

	// Checks one grant against the issue rules and logs it
	task automatic note_grant(input int port, input rob_ndx_t ndx);
		unit_t    exp_unit;
		bit       blocked;
		rob_ndx_t j;
		exp_unit = (port <= 1) ? UNIT_ALU : (port == 2) ? UNIT_FPU
			: (port == 3) ? UNIT_FCU : UNIT_MEM;
		// Any valid sync entry between head and this entry is a barrier
		blocked = 1'b0;
		j = m_head;
		while (j != ndx) begin
			if (m_v[j] && m_sync[j]) begin
				blocked = 1'b1;
			end
			j = j + 1'b1;
		end
		check_flag("unit idle at grant", idle_at_edge[port], 1'b1);
		check_flag("granted entry valid", m_v[ndx], 1'b1);
		check_flag("entry granted before", m_granted[ndx], 1'b0);
		check_flag("unit class fits port", m_unit[ndx] == exp_unit, 1'b1);
		check_flag("operands valid at grant", &m_args[ndx], 1'b1);
		check_flag("granted behind sync", blocked, 1'b0);
		if (port == 1) begin
			check_flag("alu0_only entry on alu1", m_alu0_only[ndx], 1'b0);
		end
		m_granted[ndx] = 1'b1;
		g_ndx.push_back(ndx);
		g_port.push_back(port);
		g_cyc.push_back(cycle_cnt);
	endtask

	// Applies the inputs now driven to the model, crosses one rising edge,
	// clears the strobes on the falling edge and collects the grants
	task automatic tick();
		bit exp_full;
		bit exp_commit;
		exp_full   = (m_count == ROB_ENTRIES);
		exp_commit = m_v[m_head] && m_done[m_head];
		check_flag("rob_full_o", rob_full_o, exp_full);
		check_flag("commit_v_o", commit_v_o, exp_commit);
		if (commit_v_o) begin
			check_ndx("commit_ndx_o", commit_ndx_o, m_head);
			c_ndx.push_back(commit_ndx_o);
		end
		if (exp_commit) begin
			m_v[m_head] = 1'b0;
			m_head      = m_head + 1'b1;
			m_count--;
		end
		if (wake_v_i && m_v[wake_ndx_i]) begin
			m_args[wake_ndx_i] = 3'b111;
		end
		if (done_v_i) begin
			m_done[done_ndx_i] = 1'b1;
		end
		// A full ROB drops the request and the tail stays put
		if (disp_v_i && !exp_full) begin
			m_v[m_tail]         = 1'b1;
			m_unit[m_tail]      = disp_unit_i;
			m_alu0_only[m_tail] = disp_alu0_only_i;
			m_sync[m_tail]      = disp_sync_i;
			m_args[m_tail]      = disp_args_v_i;
			m_done[m_tail]      = 1'b0;
			m_granted[m_tail]   = 1'b0;
			m_tail              = m_tail + 1'b1;
			m_count++;
		end
		idle_at_edge[0] = alu0_idle_i;
		idle_at_edge[1] = alu1_idle_i;
		idle_at_edge[2] = fpu_idle_i;
		idle_at_edge[3] = fcu_idle_i;
		idle_at_edge[4] = agen_idle_i;
		@(negedge clk);
		cycle_cnt++;
		disp_v_i = 1'b0;
		wake_v_i = 1'b0;
		done_v_i = 1'b0;
		if (alu0_rndxv_o) note_grant(0, alu0_rndx_o);
		if (alu1_rndxv_o) note_grant(1, alu1_rndx_o);
		if (fpu_rndxv_o) note_grant(2, fpu_rndx_o);
		if (fcu_rndxv_o) note_grant(3, fcu_rndx_o);
		if (agen_rndxv_o) note_grant(4, agen_rndx_o);
	endtask

	task automatic idle_ticks(input int n);
		repeat (n) tick();
	endtask

	task automatic set_idle(input logic a0, input logic a1, input logic f, input logic c,
			input logic g);
		alu0_idle_i = a0;
		alu1_idle_i = a1;
		fpu_idle_i  = f;
		fcu_idle_i  = c;
		agen_idle_i = g;
	endtask

	task automatic dispatch(input unit_t unit, input logic alu0_only, input logic sync,
			input logic [2:0] args);
		disp_v_i         = 1'b1;
		disp_unit_i      = unit;
		disp_alu0_only_i = alu0_only;
		disp_sync_i      = sync;
		disp_args_v_i    = args;
		tick();
	endtask

	task automatic mark_done(input rob_ndx_t ndx);
		done_v_i   = 1'b1;
		done_ndx_i = ndx;
		tick();
	endtask

	task automatic wait_grants(input int n, input string what);
		int waited;
		waited = 0;
		while (g_ndx.size() < n && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (g_ndx.size() < n) begin
			err_cnt++;
			$display("%s: only %0d of %0d grants arrived in time", what, g_ndx.size(), n);
		end
	endtask

	function automatic bit all_granted();
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (m_v[i] && !m_granted[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic clear_logs();
		g_ndx.delete();
		g_port.delete();
		g_cyc.delete();
		c_ndx.delete();
	endtask

	// Lets every entry issue, completes it and waits for the ROB to empty
	task automatic drain();
		int   waited;
		logic pending [ROB_ENTRIES];
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		waited = 0;
		while (!all_granted() && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			pending[i] = m_v[i] && m_granted[i] && !m_done[i];
		end
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (pending[i]) mark_done(rob_ndx_t'(i));
		end
		waited = 0;
		while (m_count != 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (m_count != 0) begin
			err_cnt++;
			$display("ROB did not drain, %0d entries are still held", m_count);
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests_run++;
		$display("%-16s finished with %0d errors", name, err_cnt - errs_before);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_alu_pairs();
		int       errs;
		rob_ndx_t base;
		errs = err_cnt;
		clear_logs();
		base = m_tail;
		// Both ALUs busy while the four entries arrive, so they issue in pairs
		set_idle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
		for (int k = 0; k < 4; k++) begin
			dispatch(UNIT_ALU, 1'b0, 1'b0, 3'b111);
		end
		idle_ticks(4);
		check_flag("ALU grant with both ALUs busy", g_ndx.size() == 0, 1'b1);
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		wait_grants(4, "alu pairs");
		if (g_ndx.size() >= 4) begin
			for (int k = 0; k < 4; k++) begin
				check_ndx("grant in age order", g_ndx[k], base + rob_ndx_t'(k));
				check_flag("alu0 takes older of pair", g_port[k] == k % 2, 1'b1);
			end
			check_flag("first pair in one cycle", g_cyc[0] == g_cyc[1], 1'b1);
			check_flag("second pair in one cycle", g_cyc[2] == g_cyc[3], 1'b1);
			check_flag("pairs back to back", g_cyc[2] == g_cyc[0] + 1, 1'b1);
		end
		idle_ticks(4);
		check_flag("no grant beyond four", g_ndx.size() == 4, 1'b1);
		drain();
		report("alu pairs", errs);
	endtask

	task automatic test_routing();
		int         errs;
		logic [3:0] r;
		unit_t      u;
		errs = err_cnt;
		clear_logs();
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		// Random classes, the port checks live in note_grant
		for (int k = 0; k < 6; k++) begin
			r = rand_bits(2);
			u = unit_t'(r[1:0]);
			dispatch(u, (u == UNIT_ALU) ? rand_bit() : 1'b0, 1'b0, 3'b111);
		end
		wait_grants(6, "routing");
		drain();
		clear_logs();
		set_idle(1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
		dispatch(UNIT_ALU, 1'b1, 1'b0, 3'b111);
		idle_ticks(6);
		check_flag("alu0_only waits for alu0", g_ndx.size() == 0, 1'b1);
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		wait_grants(1, "alu0_only");
		if (g_ndx.size() >= 1) begin
			check_flag("alu0_only on alu0", g_port[0] == 0, 1'b1);
		end
		drain();
		report("routing", errs);
	endtask

	task automatic test_idle_wake();
		int         errs;
		int         k;
		logic [3:0] r;
		logic [3:0] clr;
		logic [2:0] args;
		rob_ndx_t   widx;
		errs = err_cnt;
		clear_logs();
		set_idle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
		dispatch(UNIT_ALU, 1'b0, 1'b0, 3'b111);
		idle_ticks(8);
		check_flag("ALU grant while busy", g_ndx.size() == 0, 1'b1);
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		wait_grants(1, "idle release");
		idle_ticks(4);
		check_flag("single grant after release", g_ndx.size() == 1, 1'b1);
		drain();
		clear_logs();
		// Random operand bits with one of them forced clear
		r    = rand_bits(3);
		clr  = rand_bits(2);
		k    = int'(clr) % 3;
		args = r[2:0] & ~(3'b001 << k);
		widx = m_tail;
		dispatch(UNIT_ALU, 1'b0, 1'b0, args);
		idle_ticks(8);
		check_flag("grant before wake", g_ndx.size() == 0, 1'b1);
		wake_v_i   = 1'b1;
		wake_ndx_i = widx;
		tick();
		wait_grants(1, "wake");
		if (g_ndx.size() >= 1) begin
			check_ndx("woken entry granted", g_ndx[0], widx);
		end
		drain();
		report("idle and wake", errs);
	endtask

	task automatic test_sync_barrier();
		int       errs;
		rob_ndx_t sidx;
		errs = err_cnt;
		clear_logs();
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		sidx = m_tail;
		dispatch(UNIT_ALU, 1'b0, 1'b1, 3'b111);
		dispatch(UNIT_ALU, 1'b0, 1'b0, 3'b111);
		dispatch(UNIT_FPU, 1'b0, 1'b0, 3'b111);
		dispatch(UNIT_MEM, 1'b0, 1'b0, 3'b111);
		wait_grants(1, "sync entry");
		idle_ticks(10);
		check_flag("younger held behind sync", g_ndx.size() == 1, 1'b1);
		if (g_ndx.size() >= 1) begin
			check_ndx("sync entry issued first", g_ndx[0], sidx);
		end
		mark_done(sidx);
		wait_grants(4, "after sync retire");
		check_flag("sync entry retired", c_ndx.size() == 1, 1'b1);
		if (c_ndx.size() >= 1) begin
			check_ndx("retired entry", c_ndx[0], sidx);
		end
		drain();
		report("sync barrier", errs);
	endtask

	task automatic test_retire_full();
		int         errs;
		rob_ndx_t   base;
		logic [3:0] r;
		errs = err_cnt;
		clear_logs();
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		base = m_tail;
		for (int k = 0; k < 3; k++) begin
			dispatch(UNIT_ALU, 1'b0, 1'b0, 3'b111);
		end
		wait_grants(3, "retire order");
		// The youngest completes first and has to wait for the head
		mark_done(base + rob_ndx_t'(2));
		idle_ticks(5);
		check_flag("no retire past head", c_ndx.size() == 0, 1'b1);
		mark_done(base);
		mark_done(base + rob_ndx_t'(1));
		idle_ticks(3);
		check_flag("all three retired", c_ndx.size() == 3, 1'b1);
		for (int k = 0; k < c_ndx.size() && k < 3; k++) begin
			check_ndx("retire in dispatch order", c_ndx[k], base + rob_ndx_t'(k));
		end
		drain();
		clear_logs();
		// No grants and no retire, so the ROB fills after sixteen entries
		set_idle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		for (int k = 0; k < ROB_ENTRIES + 2; k++) begin
			r = rand_bits(2);
			dispatch(unit_t'(r[1:0]), 1'b0, 1'b0, 3'b111);
		end
		check_flag("rob_full_o after overfill", rob_full_o, 1'b1);
		drain();
		// Only the sixteen accepted entries ever leave the ROB
		check_flag("sixteen entries retired", c_ndx.size() == ROB_ENTRIES, 1'b1);
		report("retire and full", errs);
	endtask

	// ========================================================================
	// Run control
	// ========================================================================

	initial begin
		lfsr_state       = 32'h152d81c9;
		rst              = 1'b1;
		disp_v_i         = 1'b0;
		disp_unit_i      = UNIT_ALU;
		disp_alu0_only_i = 1'b0;
		disp_sync_i      = 1'b0;
		disp_args_v_i    = 3'b000;
		wake_v_i         = 1'b0;
		wake_ndx_i       = '0;
		done_v_i         = 1'b0;
		done_ndx_i       = '0;
		set_idle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			m_v[i]       = 1'b0;
			m_done[i]    = 1'b0;
			m_granted[i] = 1'b0;
		end
		m_head    = '0;
		m_tail    = '0;
		m_count   = 0;
		cycle_cnt = 0;
		err_cnt   = 0;
		check_cnt = 0;
		tests_run = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_alu_pairs();
		test_routing();
		test_idle_wake();
		test_sync_barrier();
		test_retire_full();
		$display("Tests run %0d, checks %0d, errors %0d", tests_run, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Budget covers reset plus a fixed number of cycles for every test
	initial begin
		repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog expired, the tests did not finish within their cycle budget");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/issue_stage.sv
// Top level of the issue stage, ties the ROB to the two scans and the selector
// Dispatch, wake and completion come from outside, grants and retire go out

`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 disp_v_i,
	input  wire sched_pkg::unit_t     disp_unit_i,
	input  wire logic                 disp_alu0_only_i,
	input  wire logic                 disp_sync_i,
	input  wire logic [2:0]           disp_args_v_i,
	input  wire logic                 wake_v_i,
	input  wire sched_pkg::rob_ndx_t  wake_ndx_i,
	input  wire logic                 done_v_i,
	input  wire sched_pkg::rob_ndx_t  done_ndx_i,
	input  wire logic                 alu0_idle_i,
	input  wire logic                 alu1_idle_i,
	input  wire logic                 fpu_idle_i,
	input  wire logic                 fcu_idle_i,
	input  wire logic                 agen_idle_i,
	output sched_pkg::rob_ndx_t       alu0_rndx_o,
	output logic                      alu0_rndxv_o,
	output sched_pkg::rob_ndx_t       alu1_rndx_o,
	output logic                      alu1_rndxv_o,
	output sched_pkg::rob_ndx_t       fpu_rndx_o,
	output logic                      fpu_rndxv_o,
	output sched_pkg::rob_ndx_t       fcu_rndx_o,
	output logic                      fcu_rndxv_o,
	output sched_pkg::rob_ndx_t       agen_rndx_o,
	output logic                      agen_rndxv_o,
	output logic                      commit_v_o,
	output sched_pkg::rob_ndx_t       commit_ndx_o,
	output logic                      rob_full_o
);

	import sched_pkg::*;

	rob_array_t rob;
	rob_ndx_t   head;
	rob_mask_t  ready_mask;
	rob_mask_t  block_mask;
	// Registered grants feed back into the ROB and the readiness scan
	rob_mask_t  issue_mask;

	rob_table rob_table_i (
		.clk              (clk),
		.rst              (rst),
		.disp_v_i         (disp_v_i),
		.disp_unit_i      (disp_unit_i),
		.disp_alu0_only_i (disp_alu0_only_i),
		.disp_sync_i      (disp_sync_i),
		.disp_args_v_i    (disp_args_v_i),
		.wake_v_i         (wake_v_i),
		.wake_ndx_i       (wake_ndx_i),
		.done_v_i         (done_v_i),
		.done_ndx_i       (done_ndx_i),
		.issue_mask_i     (issue_mask),
		.rob_o            (rob),
		.head_o           (head),
		.commit_v_o       (commit_v_o),
		.commit_ndx_o     (commit_ndx_o),
		.rob_full_o       (rob_full_o)
	);

	ready_scan ready_scan_i (
		.clk          (clk),
		.rst          (rst),
		.rob_i        (rob),
		.issue_mask_i (issue_mask),
		.ready_o      (ready_mask)
	);

	sync_scan sync_scan_i (
		.clk     (clk),
		.rst     (rst),
		.rob_i   (rob),
		.head_i  (head),
		.block_o (block_mask)
	);

	issue_select issue_select_i (
		.clk          (clk),
		.rst          (rst),
		.rob_i        (rob),
		.head_i       (head),
		.ready_i      (ready_mask),
		.block_i      (block_mask),
		.alu0_idle_i  (alu0_idle_i),
		.alu1_idle_i  (alu1_idle_i),
		.fpu_idle_i   (fpu_idle_i),
		.fcu_idle_i   (fcu_idle_i),
		.agen_idle_i  (agen_idle_i),
		.issue_mask_o (issue_mask),
		.alu0_rndx_o  (alu0_rndx_o),
		.alu0_rndxv_o (alu0_rndxv_o),
		.alu1_rndx_o  (alu1_rndx_o),
		.alu1_rndxv_o (alu1_rndxv_o),
		.fpu_rndx_o   (fpu_rndx_o),
		.fpu_rndxv_o  (fpu_rndxv_o),
		.fcu_rndx_o   (fcu_rndx_o),
		.fcu_rndxv_o  (fcu_rndxv_o),
		.agen_rndx_o  (agen_rndx_o),
		.agen_rndxv_o (agen_rndxv_o)
	);

endmodule

`default_nettype wire

// File: hdl/issue_select.sv
// Oldest-first issue selector for two ALUs, one FPU, one FCU and one AGEN
// Grants and the matching issue mask are registered and last one cycle

`timescale 1ns/1ps
`default_nettype none

module issue_select (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire sched_pkg::rob_array_t rob_i,
	input  wire sched_pkg::rob_ndx_t   head_i,
	input  wire sched_pkg::rob_mask_t  ready_i,
	input  wire sched_pkg::rob_mask_t  block_i,
	input  wire logic                  alu0_idle_i,
	input  wire logic                  alu1_idle_i,
	input  wire logic                  fpu_idle_i,
	input  wire logic                  fcu_idle_i,
	input  wire logic                  agen_idle_i,
	output sched_pkg::rob_mask_t       issue_mask_o,
	output sched_pkg::rob_ndx_t        alu0_rndx_o,
	output logic                       alu0_rndxv_o,
	output sched_pkg::rob_ndx_t        alu1_rndx_o,
	output logic                       alu1_rndxv_o,
	output sched_pkg::rob_ndx_t        fpu_rndx_o,
	output logic                       fpu_rndxv_o,
	output sched_pkg::rob_ndx_t        fcu_rndx_o,
	output logic                       fcu_rndxv_o,
	output sched_pkg::rob_ndx_t        agen_rndx_o,
	output logic                       agen_rndxv_o
);

	import sched_pkg::*;

	rob_mask_t next_mask;
	rob_ndx_t  next_alu0_rndx;
	rob_ndx_t  next_alu1_rndx;
	rob_ndx_t  next_fpu_rndx;
	rob_ndx_t  next_fcu_rndx;
	rob_ndx_t  next_agen_rndx;
	logic      next_alu0_v;
	logic      next_alu1_v;
	logic      next_fpu_v;
	logic      next_fcu_v;
	logic      next_agen_v;
	rob_ndx_t  idx;
	logic      cand;
	logic [2:0] grant_cnt;

	// ========================================================================
	// Age-ordered walk
	// ========================================================================

	always_comb begin
		next_mask      = '0;
		next_alu0_rndx = '0;
		next_alu1_rndx = '0;
		next_fpu_rndx  = '0;
		next_fcu_rndx  = '0;
		next_agen_rndx = '0;
		next_alu0_v    = 1'b0;
		next_alu1_v    = 1'b0;
		next_fpu_v     = 1'b0;
		next_fcu_v     = 1'b0;
		next_agen_v    = 1'b0;
		idx            = head_i;
		cand           = 1'b0;

		for (int hd = 0; hd < ROB_ENTRIES; hd++) begin
			idx = head_i + rob_ndx_t'(hd);
			// Entries granted last cycle are still in flight towards the ROB
			// and must be skipped here, otherwise they would issue twice
			cand = ready_i[idx] && !block_i[idx] && !issue_mask_o[idx]
				&& rob_i[idx].v && !rob_i[idx].done;

			if (cand) begin
				// Each case arm grants at most one unit, so an entry never
				// goes to two units in the same cycle
				case (rob_i[idx].unit)
					UNIT_ALU: begin
						if (alu0_idle_i && !next_alu0_v) begin
							next_alu0_v    = 1'b1;
							next_alu0_rndx = idx;
							next_mask[idx] = 1'b1;
						end else if (alu1_idle_i && !next_alu1_v
								&& !rob_i[idx].alu0_only) begin
							next_alu1_v    = 1'b1;
							next_alu1_rndx = idx;
							next_mask[idx] = 1'b1;
						end
					end
					UNIT_FPU: begin
						if (fpu_idle_i && !next_fpu_v) begin
							next_fpu_v     = 1'b1;
							next_fpu_rndx  = idx;
							next_mask[idx] = 1'b1;
						end
					end
					UNIT_FCU: begin
						if (fcu_idle_i && !next_fcu_v) begin
							next_fcu_v     = 1'b1;
							next_fcu_rndx  = idx;
							next_mask[idx] = 1'b1;
						end
					end
					default: begin
						// Loads and stores start at the address generator
						if (agen_idle_i && !next_agen_v) begin
							next_agen_v    = 1'b1;
							next_agen_rndx = idx;
							next_mask[idx] = 1'b1;
						end
					end
				endcase
			end
		end
	end

	// ========================================================================
	// Grant registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_mask_o <= '0;
			alu0_rndxv_o <= 1'b0;
			alu1_rndxv_o <= 1'b0;
			fpu_rndxv_o  <= 1'b0;
			fcu_rndxv_o  <= 1'b0;
			agen_rndxv_o <= 1'b0;
		end else begin
			issue_mask_o <= next_mask;
			alu0_rndxv_o <= next_alu0_v;
			alu1_rndxv_o <= next_alu1_v;
			fpu_rndxv_o  <= next_fpu_v;
			fcu_rndxv_o  <= next_fcu_v;
			agen_rndxv_o <= next_agen_v;
		end
	end

	// Granted ROB index of each unit, read together with its valid bit
	always_ff @(posedge clk) begin
		alu0_rndx_o <= next_alu0_rndx;
		alu1_rndx_o <= next_alu1_rndx;
		fpu_rndx_o  <= next_fpu_rndx;
		fcu_rndx_o  <= next_fcu_rndx;
		agen_rndx_o <= next_agen_rndx;
	end

	// ========================================================================
	// Checks
	// ========================================================================

	assign grant_cnt = 3'(alu0_rndxv_o) + 3'(alu1_rndxv_o) + 3'(fpu_rndxv_o)
		+ 3'(fcu_rndxv_o) + 3'(agen_rndxv_o);

	// Every valid grant must claim its own bit in the issue mask, which
	// rules out two units sharing an index
	a_grant_unique: assert property (@(posedge clk) disable iff (rst)
		$countones(issue_mask_o) == int'(grant_cnt));

	// The entry granted to alu1 is still in the ROB one cycle later
	a_alu1_not_alu0_only: assert property (@(posedge clk) disable iff (rst)
		alu1_rndxv_o |-> !rob_i[alu1_rndx_o].alu0_only);

endmodule

`default_nettype wire

// File: hdl/sync_scan.sv
// Barrier mask for instructions behind an unretired sync instruction
// Age is measured as distance from the ROB head, the result is registered once

`timescale 1ns/1ps
`default_nettype none

module sync_scan (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire sched_pkg::rob_array_t rob_i,
	input  wire sched_pkg::rob_ndx_t   head_i,
	output sched_pkg::rob_mask_t       block_o
);

	import sched_pkg::*;

	// Distance of every entry from head, zero is the oldest
	rob_ndx_t  age [ROB_ENTRIES];
	rob_mask_t block_d;

	// ========================================================================
	// Age and barrier
	// ========================================================================

	always_comb begin
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			// Four bit subtraction wraps, which gives the circular distance
			age[i] = rob_ndx_t'(i) - head_i;
		end

		for (int i = 0; i < ROB_ENTRIES; i++) begin
			block_d[i] = 1'b0;
			// Any valid sync entry strictly older than this one holds it back
			// The sync entry itself is never blocked by its own flag
			for (int j = 0; j < ROB_ENTRIES; j++) begin
				if (rob_i[j].v && rob_i[j].sync && age[j] < age[i]) begin
					block_d[i] = 1'b1;
				end
			end
		end
	end

	// The barrier lifts one cycle after the sync entry retires
	always_ff @(posedge clk) begin
		if (rst) begin
			block_o <= '0;
		end else begin
			block_o <= block_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ready_scan.sv
// Per-entry readiness mask for the issue selector, registered once
// An entry is ready when it is valid, not yet issued, not done and all operands are valid

`timescale 1ns/1ps
`default_nettype none

module ready_scan (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire sched_pkg::rob_array_t rob_i,
	input  wire sched_pkg::rob_mask_t  issue_mask_i,
	output sched_pkg::rob_mask_t       ready_o
);

	import sched_pkg::*;

	rob_mask_t ready_d;

	// ========================================================================
	// Readiness rule
	// ========================================================================

	always_comb begin
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			// The issue mask bit covers the cycle between a grant and the
			// out bit showing up in the ROB
			ready_d[i] = rob_i[i].v
				&& !rob_i[i].out
				&& !rob_i[i].done
				&& (&rob_i[i].args_v)
				&& !issue_mask_i[i];
		end
	end

	// One register stage keeps the scan off the selector's critical path
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_o <= '0;
		end else begin
			ready_o <= ready_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rob_table.sv
// Reorder buffer storage with dispatch at the tail and retire at the head
// Wake, completion and issue marking update entries in place every cycle

`timescale 1ns/1ps
`default_nettype none

module rob_table (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 disp_v_i,
	input  wire sched_pkg::unit_t     disp_unit_i,
	input  wire logic                 disp_alu0_only_i,
	input  wire logic                 disp_sync_i,
	input  wire logic [2:0]           disp_args_v_i,
	input  wire logic                 wake_v_i,
	input  wire sched_pkg::rob_ndx_t  wake_ndx_i,
	input  wire logic                 done_v_i,
	input  wire sched_pkg::rob_ndx_t  done_ndx_i,
	input  wire sched_pkg::rob_mask_t issue_mask_i,
	output sched_pkg::rob_array_t     rob_o,
	output sched_pkg::rob_ndx_t       head_o,
	output logic                      commit_v_o,
	output sched_pkg::rob_ndx_t       commit_ndx_o,
	output logic                      rob_full_o
);

	import sched_pkg::*;

	rob_array_t           rob_q;
	rob_ndx_t             head_q;
	rob_ndx_t             tail_q;
	// One bit wider than an index so a full ROB can be told from an empty one
	logic [ROB_NDX_W:0]   count_q;
	logic                 disp_accept;
	logic                 retire;

	assign rob_full_o = (count_q == (ROB_NDX_W+1)'(ROB_ENTRIES));

	// A full ROB silently drops the dispatch request
	assign disp_accept = disp_v_i && !rob_full_o;

	// Retire is decided combinationally from the head entry
	assign retire = rob_q[head_q].v && rob_q[head_q].done;

	assign commit_v_o   = retire;
	assign commit_ndx_o = head_q;
	assign rob_o        = rob_q;
	assign head_o       = head_q;

	// ========================================================================
	// Entry update
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				rob_q[i].v <= 1'b0;
			end
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				// A granted entry stays out until it retires
				if (issue_mask_i[i]) begin
					rob_q[i].out <= 1'b1;
				end
				// Wake makes every operand of the entry available at once
				if (wake_v_i && wake_ndx_i == rob_ndx_t'(i) && rob_q[i].v) begin
					rob_q[i].args_v <= 3'b111;
				end
				if (done_v_i && done_ndx_i == rob_ndx_t'(i)) begin
					rob_q[i].done <= 1'b1;
				end
			end

			// Head and tail only meet on an empty or full ROB, so retire and
			// dispatch never touch the same slot in one cycle
			if (retire) begin
				rob_q[head_q].v <= 1'b0;
				head_q          <= head_q + 1'b1;
			end

			if (disp_accept) begin
				rob_q[tail_q] <= '{
					v:         1'b1,
					unit:      disp_unit_i,
					alu0_only: disp_alu0_only_i,
					sync:      disp_sync_i,
					args_v:    disp_args_v_i,
					out:       1'b0,
					done:      1'b0
				};
				tail_q <= tail_q + 1'b1;
			end

			count_q <= count_q + (ROB_NDX_W+1)'(disp_accept) - (ROB_NDX_W+1)'(retire);
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Completion must target an entry that is still in flight
	a_done_on_valid: assert property (@(posedge clk) disable iff (rst)
		done_v_i |-> rob_q[done_ndx_i].v);

	// The count and the pointers must agree, so an accepted dispatch
	// always lands in a free slot and never overwrites a live entry
	a_disp_not_full: assert property (@(posedge clk) disable iff (rst)
		disp_accept |-> !rob_q[tail_q].v);

endmodule

`default_nettype wire

// File: hdl/sched_pkg.sv
// Shared sizes and types for the out-of-order issue stage
// Import this package in every block that handles ROB entries or masks

`default_nettype none

package sched_pkg;

	// ========================================================================
	// ROB sizing
	// ========================================================================

	// Number of reorder buffer entries, the scan window covers all of them
	localparam int ROB_ENTRIES = 16;

	// Width of an entry index, also the width of the head and tail pointers
	localparam int ROB_NDX_W = $clog2(ROB_ENTRIES);

	// Index into the ROB, wraps naturally at ROB_ENTRIES
	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;

	// One bit per ROB entry, bit n belongs to entry n
	typedef logic [ROB_ENTRIES-1:0] rob_mask_t;

	// ========================================================================
	// Entry record
	// ========================================================================

	// Functional unit class of an instruction
	// UNIT_MEM goes to the address generator
	typedef enum logic [1:0] {
		UNIT_ALU = 2'd0,
		UNIT_FPU = 2'd1,
		UNIT_FCU = 2'd2,
		UNIT_MEM = 2'd3
	} unit_t;

	// One ROB entry
	// The out bit is set once the entry has been granted to a unit
	// The done bit is set by the completion strobe and allows retire
	typedef struct packed {
		logic       v;
		unit_t      unit;
		logic       alu0_only;
		logic       sync;
		logic [2:0] args_v;
		logic       out;
		logic       done;
	} rob_entry_t;

	// Whole ROB as one packed vector so it can travel through ports
	typedef rob_entry_t [ROB_ENTRIES-1:0] rob_array_t;

endpackage

`default_nettype wire
